// ==== vlog.f ====
+incdir+design
design/titan_pkg.sv
design/titan_exu.sv
design/titan_muldiv_ctrl.sv
design/titan_muldiv_count.sv
design/titan_muldiv_datapath.sv
design/titan_exmem_register.sv
design/titan_ex_stage.sv
test/tb_titan_ex_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_titan_ex_stage
FILELIST  = vlog.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== test/tb_titan_ex_stage.sv ====
//==================================================
// self-checking testbench for the execute stage
// reference model, stimulus tasks and compare process
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module tb_titan_ex_stage
	import titan_pkg::*;
();

	localparam int N_ALU      = 200;
	localparam int N_MD       = 20;
	localparam int MAX_CYCLES = N_ALU + N_MD * 40 + 50;

	typedef struct packed {
		word_t    pc;
		word_t    instruction;
		word_t    result;
		word_t    store_data;
		ex_ctrl_t ctrl;
		ex_exc_t  exc;
		ex_csr_t  csr;
	} mem_rec_t;

	logic     clk;
	logic     arst_n;
	logic     stall;
	logic     flush;
	word_t    pc;
	word_t    instruction;
	word_t    port_a;
	word_t    port_b;
	alu_op_t  alu_op;
	ex_ctrl_t ctrl;
	ex_exc_t  exc;
	ex_csr_t  csr;
	logic     busy;
	word_t    ex_fwd_dat;
	word_t    mem_pc;
	word_t    mem_instruction;
	word_t    mem_result;
	word_t    mem_store_data;
	ex_ctrl_t mem_ctrl;
	ex_exc_t  mem_exc;
	ex_csr_t  mem_csr;

	mem_rec_t exp_next;   // what the register should hold after the coming edge.
	mem_rec_t exp_cur;
	logic     chk_next;
	logic     chk_cur;
	integer   seed;
	int       errors;
	int       checks;
	int       cycles = 0;

	titan_ex_stage i_dut (
		.clk_i             (clk),
		.arst_n_i          (arst_n),
		.stall_i           (stall),
		.flush_i           (flush),
		.pc_i              (pc),
		.instruction_i     (instruction),
		.port_a_i          (port_a),
		.port_b_i          (port_b),
		.alu_op_i          (alu_op),
		.ctrl_i            (ctrl),
		.exc_i             (exc),
		.csr_i             (csr),
		.busy_o            (busy),
		.ex_fwd_dat_o      (ex_fwd_dat),
		.mem_pc_o          (mem_pc),
		.mem_instruction_o (mem_instruction),
		.mem_result_o      (mem_result),
		.mem_store_data_o  (mem_store_data),
		.mem_ctrl_o        (mem_ctrl),
		.mem_exc_o         (mem_exc),
		.mem_csr_o         (mem_csr)
	);

	always #20 clk = ~clk;

	function automatic word_t rand_word();
		rand_word = $random(seed);
	endfunction

	function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
		word_t r;
		case (op)
			`TITAN_OP_ADD:  r = a + b;
			`TITAN_OP_SUB:  r = a - b;
			`TITAN_OP_AND:  r = a & b;
			`TITAN_OP_OR:   r = a | b;
			`TITAN_OP_XOR:  r = a ^ b;
			`TITAN_OP_SLL:  r = a << b[4:0];
			`TITAN_OP_SRL:  r = a >> b[4:0];
			`TITAN_OP_SRA:  r = word_t'($signed(a) >>> b[4:0]);
			`TITAN_OP_SLT:  r = {31'b0, $signed(a) < $signed(b)};
			`TITAN_OP_SLTU: r = {31'b0, a < b};
			`TITAN_OP_MUL:  r = a * b;   // low word of the product.
			`TITAN_OP_DIVU: r = (b == '0) ? '1 : a / b;
			`TITAN_OP_REMU: r = (b == '0) ? a : a % b;
			default:        r = '0;
		endcase
		return r;
	endfunction

	function automatic mem_rec_t bubble_rec();
		mem_rec_t r;
		r = '0;
		r.instruction = `TITAN_NOP;
		return r;
	endfunction

	function automatic mem_rec_t capture_rec();
		mem_rec_t r;
		r.pc          = pc;
		r.instruction = instruction;
		r.result      = alu_ref(alu_op, port_a, port_b);
		r.store_data  = port_b;
		r.ctrl        = ctrl;
		r.exc         = exc;
		r.csr         = csr;
		return r;
	endfunction

	task automatic note_error(input string name, input logic [63:0] got, input logic [63:0] want);
		errors++;
		$display("error at %0t: %s = %h, expected %h", $time, name, got, want);
	endtask

	task automatic fail_plain(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic compare_mem(input mem_rec_t want);
		checks++;
		if (mem_pc !== want.pc) note_error("mem_pc_o", 64'(mem_pc), 64'(want.pc));
		if (mem_instruction !== want.instruction) begin
			note_error("mem_instruction_o", 64'(mem_instruction), 64'(want.instruction));
		end
		if (mem_result !== want.result) note_error("mem_result_o", 64'(mem_result), 64'(want.result));
		if (mem_store_data !== want.store_data) begin
			note_error("mem_store_data_o", 64'(mem_store_data), 64'(want.store_data));
		end
		if (mem_ctrl !== want.ctrl) note_error("mem_ctrl_o", 64'(mem_ctrl), 64'(want.ctrl));
		if (mem_exc !== want.exc) note_error("mem_exc_o", 64'(mem_exc), 64'(want.exc));
		if (mem_csr !== want.csr) note_error("mem_csr_o", 64'(mem_csr), 64'(want.csr));
	endtask

	// the register output is settled 1 ns after the edge.
	always @(posedge clk) begin
		exp_cur = exp_next;
		chk_cur = chk_next;
		#1;
		if (chk_cur) compare_mem(exp_cur);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run did not end within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic drive_op(input alu_op_t op, input word_t a, input word_t b);
		word_t r;
		r = rand_word();
		alu_op      = op;
		port_a      = a;
		port_b      = b;
		pc          = rand_word() & 32'hffff_fffc;
		instruction = rand_word();
		ctrl        = ex_ctrl_t'(r[11:0]);
		ctrl.we     = 1'b1;   // so that a leaked write-back shows up.
		exc         = ex_exc_t'(r[17:12]);
		csr.data    = rand_word();
		csr.addr    = r[29:18];
		csr.op      = csr_op_t'(rand_word() % 8);
	endtask

	task automatic apply_alu(input alu_op_t op, input word_t a, input word_t b);
		word_t want;
		drive_op(op, a, b);
		exp_next = capture_rec();
		chk_next = 1'b1;
		want     = alu_ref(op, a, b);
		#1;
		checks++;
		if (ex_fwd_dat !== want) note_error("ex_fwd_dat_o", 64'(ex_fwd_dat), 64'(want));
	endtask

	task automatic apply_muldiv(input alu_op_t op, input word_t a, input word_t b);
		int busy_cnt;
		busy_cnt = 0;
		drive_op(op, a, b);
		exp_next = bubble_rec();   // every busy cycle retires a bubble.
		chk_next = 1'b1;
		#1;
		while (busy && busy_cnt < 40) begin
			busy_cnt++;
			@(negedge clk);
			#1;
		end
		checks++;
		if (busy_cnt != 33) fail_plain($sformatf("busy_o high for %0d cycles, not 33", busy_cnt));
		exp_next = capture_rec();
		if (ex_fwd_dat !== alu_ref(op, a, b)) begin
			note_error("ex_fwd_dat_o", 64'(ex_fwd_dat), 64'(alu_ref(op, a, b)));
		end
	endtask

	initial begin
		word_t   b;
		alu_op_t op;
		seed        = 52;
		errors      = 0;
		checks      = 0;
		clk         = 1'b0;
		arst_n      = 1'b0;
		stall       = 1'b0;
		flush       = 1'b0;
		pc          = '0;
		instruction = '0;
		port_a      = '0;
		port_b      = '0;
		alu_op      = `TITAN_OP_ADD;
		ctrl        = '0;
		exc         = '0;
		csr         = '0;
		chk_next    = 1'b0;
		exp_next    = bubble_rec();

		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		#1;
		checks++;
		if (mem_ctrl.we !== 1'b0) note_error("mem_ctrl_o.we", 64'(mem_ctrl.we), 64'(0));
		if (mem_exc !== '0) note_error("mem_exc_o", 64'(mem_exc), 64'(0));
		if (mem_instruction !== `TITAN_NOP) begin
			note_error("mem_instruction_o", 64'(mem_instruction), 64'(`TITAN_NOP));
		end

		for (int i = 0; i < N_ALU; i++) begin
			@(negedge clk);
			apply_alu(alu_op_t'(rand_word() % 10), rand_word(), rand_word());
		end

		// three stalled cycles keep the last capture, then flush beats stall.
		@(negedge clk);
		stall = 1'b1;
		repeat (3) begin
			drive_op(alu_op_t'(rand_word() % 10), rand_word(), rand_word());
			@(negedge clk);
		end
		flush    = 1'b1;
		exp_next = bubble_rec();
		@(negedge clk);
		stall = 1'b0;
		flush = 1'b0;
		apply_alu(`TITAN_OP_ADD, rand_word(), rand_word());

		for (int i = 0; i < N_MD; i++) begin
			b  = rand_word();
			op = alu_op_t'(32'd10 + rand_word() % 3);
			if (i % 5 == 0) b = '0;
			if (i % 5 == 1) b = b & 32'h0000_00ff;
			if (i % 10 == 0) op = `TITAN_OP_DIVU;   // zero divisor for both divide codes.
			if (i % 10 == 5) op = `TITAN_OP_REMU;
			@(negedge clk);
			apply_muldiv(op, rand_word(), b);
		end

		@(negedge clk);
		drive_op(`TITAN_OP_DIVU, rand_word(), rand_word() & 32'h0000_ffff);
		exp_next = bubble_rec();
		repeat (10) begin
			@(negedge clk);
			#1;
			if (!busy) fail_plain("busy_o dropped in the middle of the divide");
		end
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		#1;
		checks++;
		if (mem_ctrl.we !== 1'b0) note_error("mem_ctrl_o.we", 64'(mem_ctrl.we), 64'(0));
		apply_alu(alu_op_t'(rand_word() % 10), rand_word(), rand_word());
		if (busy !== 1'b0) fail_plain("busy_o still high in the cycle after the flush");
		@(negedge clk);
		chk_next = 1'b0;

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== design/titan_ex_stage.sv ====
//==================================================
// execute stage top with alu, muldiv and ex/mem register
//==================================================
`timescale 1ns/1ps

module titan_ex_stage
	import titan_pkg::*;
(
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     stall_i,
	input  logic     flush_i,
	input  word_t    pc_i,
	input  word_t    instruction_i,
	input  word_t    port_a_i,
	input  word_t    port_b_i,
	input  alu_op_t  alu_op_i,
	input  ex_ctrl_t ctrl_i,
	input  ex_exc_t  exc_i,
	input  ex_csr_t  csr_i,
	output logic     busy_o,
	output word_t    ex_fwd_dat_o,
	output word_t    mem_pc_o,
	output word_t    mem_instruction_o,
	output word_t    mem_result_o,
	output word_t    mem_store_data_o,
	output ex_ctrl_t mem_ctrl_o,
	output ex_exc_t  mem_exc_o,
	output ex_csr_t  mem_csr_o
);

	word_t alu_result;
	word_t md_result;
	word_t ex_result;
	logic  md_start;
	logic  md_step;
	logic  md_last;
	logic  md_done;
	logic  bubble;

	titan_exu i_exu (
		.port_a_i (port_a_i),
		.port_b_i (port_b_i),
		.alu_op_i (alu_op_i),
		.result_o (alu_result)
	);

	titan_muldiv_ctrl i_muldiv_ctrl (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.alu_op_i   (alu_op_i),
		.flush_i    (flush_i),
		.stall_i    (stall_i),
		.md_last_i  (md_last),
		.md_start_o (md_start),
		.md_step_o  (md_step),
		.md_done_o  (md_done),
		.busy_o     (busy_o)
	);

	titan_muldiv_count i_muldiv_count (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.load_i   (md_start),
		.step_i   (md_step),
		.last_o   (md_last)
	);

	titan_muldiv_datapath i_muldiv_datapath (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.start_i  (md_start),
		.step_i   (md_step),
		.op_i     (alu_op_i),
		.port_a_i (port_a_i),
		.port_b_i (port_b_i),
		.result_o (md_result)
	);

	assign ex_result    = md_done ? md_result : alu_result;
	assign ex_fwd_dat_o = ex_result;
	assign bubble       = busy_o | flush_i;   // nothing retires while muldiv is working.

	titan_exmem_register i_exmem_register (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.stall_i       (stall_i),
		.bubble_i      (bubble),
		.pc_i          (pc_i),
		.instruction_i (instruction_i),
		.result_i      (ex_result),
		.store_data_i  (port_b_i),
		.ctrl_i        (ctrl_i),
		.exc_i         (exc_i),
		.csr_i         (csr_i),
		.pc_o          (mem_pc_o),
		.instruction_o (mem_instruction_o),
		.result_o      (mem_result_o),
		.store_data_o  (mem_store_data_o),
		.ctrl_o        (mem_ctrl_o),
		.exc_o         (mem_exc_o),
		.csr_o         (mem_csr_o)
	);

endmodule

// ==== design/titan_exmem_register.sv ====
//==================================================
// ex/mem pipeline register with stall and bubble
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module titan_exmem_register
	import titan_pkg::*;
(
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     stall_i,
	input  logic     bubble_i,
	input  word_t    pc_i,
	input  word_t    instruction_i,
	input  word_t    result_i,
	input  word_t    store_data_i,
	input  ex_ctrl_t ctrl_i,
	input  ex_exc_t  exc_i,
	input  ex_csr_t  csr_i,
	output word_t    pc_o,
	output word_t    instruction_o,
	output word_t    result_o,
	output word_t    store_data_o,
	output ex_ctrl_t ctrl_o,
	output ex_exc_t  exc_o,
	output ex_csr_t  csr_o
);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o          <= '0;
			instruction_o <= `TITAN_NOP;
			result_o      <= '0;
			store_data_o  <= '0;
			ctrl_o        <= '0;
			exc_o         <= '0;
			csr_o         <= '0;
		end else if (bubble_i) begin   // bubble wins over stall.
			pc_o          <= '0;
			instruction_o <= `TITAN_NOP;
			result_o      <= '0;
			store_data_o  <= '0;
			ctrl_o        <= '0;
			exc_o         <= '0;
			csr_o         <= '0;
		end else if (!stall_i) begin
			pc_o          <= pc_i;
			instruction_o <= instruction_i;
			result_o      <= result_i;
			store_data_o  <= store_data_i;
			ctrl_o        <= ctrl_i;
			exc_o         <= exc_i;
			csr_o         <= csr_i;
		end
	end

endmodule

// ==== design/titan_muldiv_datapath.sv ====
//==================================================
// shift-add multiplier and restoring divider
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module titan_muldiv_datapath
	import titan_pkg::*;
(
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    start_i,
	input  logic    step_i,
	input  alu_op_t op_i,
	input  word_t   port_a_i,
	input  word_t   port_b_i,
	output word_t   result_o
);

	alu_op_t op_q;
	word_t   a_q;     // multiplicand, or dividend shifting into quotient.
	word_t   b_q;     // multiplier, or divisor.
	word_t   acc_q;   // product, or partial remainder.

	logic [`TITAN_XLEN:0] trial;
	logic [`TITAN_XLEN:0] div_diff;
	logic                 div_fit;

	// shift the next dividend bit into the partial remainder.
	assign trial    = {acc_q, a_q[`TITAN_XLEN-1]};
	assign div_diff = trial - {1'b0, b_q};
	assign div_fit  = (trial >= {1'b0, b_q});

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			op_q <= `TITAN_OP_MUL;
		end else if (start_i) begin
			op_q <= op_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			a_q   <= port_a_i;
			b_q   <= port_b_i;
			acc_q <= '0;
		end else if (step_i) begin
			if (op_q == `TITAN_OP_MUL) begin
				if (b_q[0]) begin
					acc_q <= acc_q + a_q;
				end
				a_q <= a_q << 1;
				b_q <= b_q >> 1;
			end else begin
				// a zero divisor always fits and yields all ones.
				if (div_fit) begin
					acc_q <= div_diff[`TITAN_XLEN-1:0];
					a_q   <= {a_q[`TITAN_XLEN-2:0], 1'b1};
				end else begin
					acc_q <= trial[`TITAN_XLEN-1:0];
					a_q   <= {a_q[`TITAN_XLEN-2:0], 1'b0};
				end
			end
		end
	end

	always_comb begin
		if (op_q == `TITAN_OP_DIVU) begin
			result_o = a_q;     // quotient.
		end else begin
			result_o = acc_q;   // product low word or remainder.
		end
	end

endmodule

// ==== design/titan_muldiv_count.sv ====
//==================================================
// muldiv iteration counter
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module titan_muldiv_count (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic load_i,
	input  logic step_i,
	output logic last_o
);

	logic [4:0] cnt_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= 5'(`TITAN_MD_ITERS - 1);
		end else if (step_i) begin
			cnt_q <= cnt_q - 5'd1;
		end
	end

	assign last_o = (cnt_q == 5'd0);   // step taken at zero is the final iteration.

	// the counter never wraps into a second pass without a reload.
	a_no_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(step_i && last_o && !load_i) |=> !step_i);

endmodule

// ==== design/titan_muldiv_ctrl.sv ====
//==================================================
// multiply/divide sequencer and busy generation
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module titan_muldiv_ctrl
	import titan_pkg::*;
(
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  alu_op_t alu_op_i,
	input  logic    flush_i,
	input  logic    stall_i,
	input  logic    md_last_i,
	output logic    md_start_o,
	output logic    md_step_o,
	output logic    md_done_o,
	output logic    busy_o
);

	md_state_e state_q;
	md_state_e state_d;
	logic      is_md;

	assign is_md = (alu_op_i == `TITAN_OP_MUL) ||
	               (alu_op_i == `TITAN_OP_DIVU) ||
	               (alu_op_i == `TITAN_OP_REMU);

	always_comb begin
		state_d = state_q;
		case (state_q)
			MD_IDLE: begin
				if (is_md) begin
					state_d = MD_RUN;
				end
			end
			MD_RUN: begin
				if (md_last_i) begin
					state_d = MD_DONE;   // the last step happens in this cycle.
				end
			end
			MD_DONE: begin
				if (!stall_i) begin
					state_d = MD_IDLE;
				end
			end
			default: begin
				state_d = MD_IDLE;
			end
		endcase
		if (flush_i) begin
			state_d = MD_IDLE;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= MD_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign md_start_o = (state_q == MD_IDLE) && is_md && !flush_i;
	assign md_step_o  = (state_q == MD_RUN);
	assign md_done_o  = (state_q == MD_DONE);
	assign busy_o     = ((state_q == MD_IDLE) && is_md) || (state_q == MD_RUN);

	// a started op runs every iteration and then finishes, unless it is flushed.
	a_start_runs_iters: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
		md_start_o |-> ##(`TITAN_MD_ITERS) md_step_o ##1 md_done_o);

endmodule

// ==== design/titan_exu.sv ====
//==================================================
// single-cycle alu
//==================================================
`timescale 1ns/1ps
`include "titan_macros.svh"

module titan_exu
	import titan_pkg::*;
(
	input  word_t   port_a_i,
	input  word_t   port_b_i,
	input  alu_op_t alu_op_i,
	output word_t   result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = port_b_i[4:0];
	assign lt_signed   = $signed(port_a_i) < $signed(port_b_i);
	assign lt_unsigned = port_a_i < port_b_i;

	always_comb begin
		case (alu_op_i)
			`TITAN_OP_ADD: begin
				result_o = port_a_i + port_b_i;
			end
			`TITAN_OP_SUB: begin
				result_o = port_a_i - port_b_i;
			end
			`TITAN_OP_AND: begin
				result_o = port_a_i & port_b_i;
			end
			`TITAN_OP_OR: begin
				result_o = port_a_i | port_b_i;
			end
			`TITAN_OP_XOR: begin
				result_o = port_a_i ^ port_b_i;
			end
			`TITAN_OP_SLL: begin
				result_o = port_a_i << shamt;
			end
			`TITAN_OP_SRL: begin
				result_o = port_a_i >> shamt;
			end
			`TITAN_OP_SRA: begin
				result_o = word_t'($signed(port_a_i) >>> shamt);
			end
			`TITAN_OP_SLT: begin
				result_o = word_t'(lt_signed);
			end
			`TITAN_OP_SLTU: begin
				result_o = word_t'(lt_unsigned);
			end
			default: begin
				result_o = '0;   // muldiv codes come from the iterative unit.
			end
		endcase
	end

endmodule

// ==== design/titan_pkg.sv ====
//==================================================
// execute stage types, side-band structs, muldiv states
//==================================================
`include "titan_macros.svh"

package titan_pkg;

	typedef logic [`TITAN_XLEN-1:0]       word_t;
	typedef logic [`TITAN_REGADDR_W-1:0]  regaddr_t;
	typedef logic [`TITAN_ALU_OP_W-1:0]   alu_op_t;
	typedef logic [`TITAN_CSR_OP_W-1:0]   csr_op_t;
	typedef logic [`TITAN_CSR_ADDR_W-1:0] csr_addr_t;

	// write-back and memory control for the instruction.
	typedef struct packed {
		regaddr_t    waddr;
		logic        we;
		logic [5:0]  mem_flags;
		logic        mem_ex_sel;   // selects memory data over the ex result.
	} ex_ctrl_t;

	typedef struct packed {
		logic bad_jump_addr;
		logic bad_branch_addr;
		logic break_op;
		logic syscall_op;
		logic exc_addr_if;
		logic bus_access_fault;
	} ex_exc_t;

	typedef struct packed {
		word_t     data;
		csr_addr_t addr;
		csr_op_t   op;
	} ex_csr_t;

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_RUN,
		MD_DONE
	} md_state_e;

endpackage

// ==== design/titan_macros.svh ====
//==================================================
// widths, alu op codes, iteration count and nop word
//==================================================
`ifndef TITAN_MACROS_SVH
`define TITAN_MACROS_SVH

`define TITAN_XLEN        32
`define TITAN_REGADDR_W   5
`define TITAN_ALU_OP_W    4
`define TITAN_CSR_OP_W    3
`define TITAN_CSR_ADDR_W  12

`define TITAN_OP_ADD      4'd0
`define TITAN_OP_SUB      4'd1
`define TITAN_OP_AND      4'd2
`define TITAN_OP_OR       4'd3
`define TITAN_OP_XOR      4'd4
`define TITAN_OP_SLL      4'd5
`define TITAN_OP_SRL      4'd6
`define TITAN_OP_SRA      4'd7
`define TITAN_OP_SLT      4'd8
`define TITAN_OP_SLTU     4'd9
`define TITAN_OP_MUL      4'd10
`define TITAN_OP_DIVU     4'd11
`define TITAN_OP_REMU     4'd12

`define TITAN_MD_ITERS    32
`define TITAN_NOP         32'h0000_0013

`endif
